// ==== hdl/trig_pkg.sv ====
package trig_pkg;

	// ------------------------------
	// widths and trigger numbering

	localparam int W_DATA = 32;                        // config data
	localparam int W_ADDR = 32;                        // fetch address

	localparam int N_BREAKPOINTS    = 2;               // exact match instruction address triggers
	localparam int TINDEX_EXCEPTION = N_BREAKPOINTS;   // exception trigger follows the breakpoints
	localparam int N_TRIGGERS       = N_BREAKPOINTS + 1;
	localparam int W_TSELECT        = $clog2(N_TRIGGERS);

	// ------------------------------
	// config addresses

	localparam logic [11:0] CSR_TSELECT = 12'h7a0;
	localparam logic [11:0] CSR_TDATA1  = 12'h7a1;
	localparam logic [11:0] CSR_TDATA2  = 12'h7a2;
	localparam logic [11:0] CSR_TINFO   = 12'h7a4;

	// tdata1 field positions
	localparam int TDATA1_DMODE_BIT = 27;              // common to both trigger types
	localparam int ACTION_BIT       = 12;              // low bit of mcontrol action
	localparam int M_BIT            = 6;               // breakpoint m enable
	localparam int U_BIT            = 3;               // breakpoint u enable
	localparam int EXEC_BIT         = 2;
	localparam int ETRIG_M_BIT      = 9;               // exception trigger m enable
	localparam int ETRIG_U_BIT      = 6;               // exception trigger u enable

	// exception causes that are allowed to fire the trigger
	localparam logic [15:0] IMPLEMENTED_EXC_CAUSES = {
		4'h0,   // 15..12 reserved
		1'b1,   // ecall from M
		2'h0,   // 10..9 not implemented
		1'b1,   // ecall from U
		1'b1,   // store fault
		1'b1,   // store misaligned
		1'b1,   // load fault
		1'b1,   // load misaligned
		1'b0,   // breakpoint, never allowed
		1'b1,   // illegal instruction
		1'b1,   // fetch fault
		1'b0    // fetch misaligned cannot happen with compressed support
	};

	localparam int QUEUE_DEPTH_DEFAULT = 4;            // prefetch words

endpackage

// ==== hdl/trig_csr_bridge.sv ====
module trig_csr_bridge (
	input  logic                        clk,
	input  logic                        rst_n,

	// four-phase config port
	input  logic                        cfg_req,
	input  logic                        cfg_write,
	input  logic [11:0]                 cfg_addr,
	input  logic [trig_pkg::W_DATA-1:0] cfg_wdata,
	output logic                        cfg_ack,
	output logic [trig_pkg::W_DATA-1:0] cfg_rdata,

	// single cycle access into the trigger unit
	output logic                        acc_wen,
	output logic [11:0]                 acc_addr,
	output logic [trig_pkg::W_DATA-1:0] acc_wdata,
	input  logic [trig_pkg::W_DATA-1:0] acc_rdata
);

	logic acc_pend;     // high for the one access cycle
	logic write_q;      // request was a write
	logic start;        // fresh request seen

	// only take a request while idle, so a held req is registered once
	assign start   = cfg_req && !acc_pend && !cfg_ack;
	assign acc_wen = acc_pend && write_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_pend <= 1'b0;
			cfg_ack  <= 1'b0;
		end else begin
			acc_pend <= start;
			if (acc_pend) begin
				cfg_ack <= 1'b1;            // ack the cycle after access
			end else if (!cfg_req) begin
				cfg_ack <= 1'b0;            // master dropped req, close handshake
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			write_q   <= cfg_write;
			acc_addr  <= cfg_addr;
			acc_wdata <= cfg_wdata;
		end
		if (acc_pend && !write_q) begin
			cfg_rdata <= acc_rdata;         // held through the ack phase
		end
	end

	// ack may only come up against a pending request
	a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		!cfg_req && !cfg_ack |=> !cfg_ack);

endmodule

// ==== hdl/trig_unit.sv ====
module trig_unit (
	input  logic                        clk,
	input  logic                        rst_n,

	// config access
	input  logic [11:0]                 cfg_addr,
	input  logic                        cfg_wen,
	input  logic [trig_pkg::W_DATA-1:0] cfg_wdata,
	output logic [trig_pkg::W_DATA-1:0] cfg_rdata,

	input  logic                        trig_m_en,      // global enable for m-mode breaks
	input  logic                        x_d_mode,
	input  logic                        x_m_mode,

	// fetch lookup
	input  logic [trig_pkg::W_ADDR-1:0] fetch_addr,
	input  logic                        fetch_m_mode,

	// trap events
	input  logic                        event_exception,
	input  logic [3:0]                  event_trap_cause,

	// one flag per halfword of the fetch word
	output logic [1:0]                  break_any,
	output logic [1:0]                  break_d_mode
);

	localparam int NBP = trig_pkg::N_BREAKPOINTS;

	logic [trig_pkg::W_TSELECT-1:0] tselect;

	// ------------------------------
	// breakpoint state

	logic [NBP-1:0]              bp_dmode;
	logic [NBP-1:0]              bp_action;
	logic [NBP-1:0]              bp_m;
	logic [NBP-1:0]              bp_u;
	logic [NBP-1:0]              bp_exec;
	logic [trig_pkg::W_DATA-1:0] bp_tdata2 [NBP];
	logic [NBP-1:0]              bp_wr_ok;          // dmode triggers locked outside debug

	// exception trigger state, action fixed at 1
	logic        exc_dmode;
	logic        exc_m;
	logic        exc_u;
	logic [15:0] exc_cause;
	logic        exc_wr_ok;

	assign bp_wr_ok  = ~(bp_dmode & {NBP{!x_d_mode}});
	assign exc_wr_ok = !(exc_dmode && !x_d_mode);

	// ------------------------------
	// config write

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tselect   <= '0;
			bp_dmode  <= '0;
			bp_action <= '0;
			bp_m      <= '0;
			bp_u      <= '0;
			bp_exec   <= '0;
			for (int i = 0; i < NBP; i++) begin
				bp_tdata2[i] <= '0;
			end
			exc_dmode <= 1'b0;
			exc_m     <= 1'b0;
			exc_u     <= 1'b0;
			exc_cause <= '0;
		end else if (cfg_wen) begin
			if (cfg_addr == trig_pkg::CSR_TSELECT) begin
				tselect <= cfg_wdata[trig_pkg::W_TSELECT-1:0];
			end
			for (int i = 0; i < NBP; i++) begin
				if (int'(tselect) == i && bp_wr_ok[i]) begin
					if (cfg_addr == trig_pkg::CSR_TDATA1) begin
						if (x_d_mode) begin
							bp_dmode[i] <= cfg_wdata[trig_pkg::TDATA1_DMODE_BIT]; // debugger only
						end
						bp_action[i] <= cfg_wdata[trig_pkg::ACTION_BIT];
						bp_m[i]      <= cfg_wdata[trig_pkg::M_BIT];
						bp_u[i]      <= cfg_wdata[trig_pkg::U_BIT];
						bp_exec[i]   <= cfg_wdata[trig_pkg::EXEC_BIT];
					end
					if (cfg_addr == trig_pkg::CSR_TDATA2) begin
						bp_tdata2[i] <= {cfg_wdata[trig_pkg::W_DATA-1:1], 1'b0}; // halfword aligned
					end
				end
			end
			if (int'(tselect) == trig_pkg::TINDEX_EXCEPTION && exc_wr_ok) begin
				if (cfg_addr == trig_pkg::CSR_TDATA1) begin
					exc_dmode <= cfg_wdata[trig_pkg::TDATA1_DMODE_BIT];
					exc_m     <= cfg_wdata[trig_pkg::ETRIG_M_BIT];
					exc_u     <= cfg_wdata[trig_pkg::ETRIG_U_BIT];
				end
				if (cfg_addr == trig_pkg::CSR_TDATA2) begin
					exc_cause <= cfg_wdata[15:0] & trig_pkg::IMPLEMENTED_EXC_CAUSES;
				end
			end
		end
	end

	// ------------------------------
	// config read

	logic [trig_pkg::W_DATA-1:0] tdata1_sel;
	logic [trig_pkg::W_DATA-1:0] tdata2_sel;
	logic [trig_pkg::W_DATA-1:0] tinfo_sel;

	always_comb begin
		tdata1_sel = '0;
		tdata2_sel = '0;
		tinfo_sel  = 32'd1;                 // type 0, empty slot
		for (int i = 0; i < NBP; i++) begin
			if (int'(tselect) == i) begin
				tdata1_sel = {
					4'h2,                       // address match
					bp_dmode[i],
					6'h00,                      // maskmax, exact only
					3'b000,                     // hit, select, timing
					2'h0,                       // sizelo
					{3'h0, bp_action[i]},
					1'b0,                       // no chain
					4'h0,                       // match exact
					bp_m[i],
					2'b00,                      // reserved, no s-mode
					bp_u[i],
					bp_exec[i],
					2'b00                       // not a watchpoint
				};
				tdata2_sel = bp_tdata2[i];
				tinfo_sel  = 32'd1 << 2;
			end
		end
		if (int'(tselect) == trig_pkg::TINDEX_EXCEPTION) begin
			tdata1_sel = {
				4'h5,                           // exception trigger
				exc_dmode,
				1'b0,                           // no hit bit
				16'h0,
				exc_m,
				2'b00,
				exc_u,
				6'd1                            // action fixed to debug mode
			};
			tdata2_sel = {16'h0, exc_cause};
			tinfo_sel  = 32'd1 << 5;
		end
	end

	always_comb begin
		case (cfg_addr)
			trig_pkg::CSR_TSELECT: cfg_rdata = {{trig_pkg::W_DATA-trig_pkg::W_TSELECT{1'b0}}, tselect};
			trig_pkg::CSR_TDATA1:  cfg_rdata = tdata1_sel;
			trig_pkg::CSR_TDATA2:  cfg_rdata = tdata2_sel;
			trig_pkg::CSR_TINFO:   cfg_rdata = tinfo_sel;
			default:               cfg_rdata = '0;
		endcase
	end

	// ------------------------------
	// exception latch

	logic exc_match;
	logic break_ie;     // flag all fetches until debug mode entered

	assign exc_match = !x_d_mode && exc_dmode && (x_m_mode ? exc_m : exc_u) &&
		event_exception && exc_cause[event_trap_cause] &&
		trig_pkg::IMPLEMENTED_EXC_CAUSES[event_trap_cause];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			break_ie <= 1'b0;
		end else begin
			break_ie <= !x_d_mode && (break_ie || exc_match);
		end
	end

	// ------------------------------
	// breakpoint lookup

	logic [1:0] hw_d;   // d-mode break per halfword
	logic [1:0] hw_m;   // m-mode break per halfword

	always_comb begin
		logic hit;
		hw_d = '0;
		hw_m = '0;
		for (int i = 0; i < NBP; i++) begin
			hit = bp_exec[i] && !x_d_mode && (fetch_m_mode ? bp_m[i] : bp_u[i]) &&
				fetch_addr[trig_pkg::W_ADDR-1:2] == bp_tdata2[i][trig_pkg::W_ADDR-1:2];
			// tdata2 bit 1 picks the halfword that carries the flag
			hw_d[bp_tdata2[i][1]] = hw_d[bp_tdata2[i][1]] | (hit && bp_action[i] && bp_dmode[i]);
			hw_m[bp_tdata2[i][1]] = hw_m[bp_tdata2[i][1]] | (hit && !bp_action[i] && trig_m_en);
		end
	end

	assign break_d_mode = hw_d | {2{break_ie}};
	assign break_any    = hw_d | hw_m | {2{break_ie}};

endmodule

// ==== hdl/fetch_tag_queue.sv ====
module fetch_tag_queue #(
	parameter int DEPTH = trig_pkg::QUEUE_DEPTH_DEFAULT   // power of two
) (
	input  logic                        clk,
	input  logic                        rst_n,

	// write side
	input  logic                        push,
	input  logic [trig_pkg::W_ADDR-1:0] push_addr,
	input  logic [trig_pkg::W_DATA-1:0] push_data,
	input  logic [1:0]                  push_brk,
	input  logic [1:0]                  push_brk_d,
	output logic                        full,

	// read side
	input  logic                        pop,
	output logic                        empty,
	output logic [trig_pkg::W_ADDR-1:0] head_addr,
	output logic [trig_pkg::W_DATA-1:0] head_data,
	output logic [1:0]                  head_brk,
	output logic [1:0]                  head_brk_d
);

	localparam int W_PTR   = $clog2(DEPTH);
	localparam int W_ENTRY = trig_pkg::W_ADDR + trig_pkg::W_DATA + 4;

	logic [W_ENTRY-1:0] mem [DEPTH];     // addr, data, break flags
	logic [W_PTR:0]     wr_ptr;          // msb is the wrap bit
	logic [W_PTR:0]     rd_ptr;

	assign empty = wr_ptr == rd_ptr;
	assign full  = wr_ptr[W_PTR] != rd_ptr[W_PTR] &&
		wr_ptr[W_PTR-1:0] == rd_ptr[W_PTR-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr[W_PTR-1:0]] <= {push_addr, push_data, push_brk, push_brk_d};
		end
	end

	// head read straight from storage
	assign {head_addr, head_data, head_brk, head_brk_d} = mem[rd_ptr[W_PTR-1:0]];

	// the fetch side and the decoder must honour full and empty
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

// ==== hdl/insn_decode.sv ====
module insn_decode (
	input  logic                        clk,
	input  logic                        rst_n,

	// queue head
	input  logic                        empty,
	output logic                        pop,
	input  logic [trig_pkg::W_ADDR-1:0] head_addr,
	input  logic [trig_pkg::W_DATA-1:0] head_data,
	input  logic [1:0]                  head_brk,
	input  logic [1:0]                  head_brk_d,

	// four-phase instruction output
	output logic                        insn_req,
	input  logic                        insn_ack,
	output logic [trig_pkg::W_ADDR-1:0] insn_addr,
	output logic [31:0]                 insn_data,
	output logic                        insn_break,
	output logic                        insn_break_d_mode
);

	logic                        hw_ptr;    // next halfword in head word
	logic                        have_lo;   // low half of a split 32-bit insn waiting
	logic [15:0]                 lo_half;
	logic [trig_pkg::W_ADDR-1:0] lo_addr;
	logic                        lo_brk;
	logic                        lo_brk_d;

	logic        step;      // one halfword is consumed this cycle
	logic [15:0] cur_hw;
	logic        is_32;
	logic        emit;

	// only move on once the previous handshake has fully closed
	assign step   = !insn_req && !insn_ack && !empty;
	assign cur_hw = hw_ptr ? head_data[31:16] : head_data[15:0];
	assign is_32  = cur_hw[1:0] == 2'b11;

	// a split insn completes on halfword 0, an upper start only stashes
	assign emit = step && (have_lo || !hw_ptr || !is_32);
	assign pop  = step && !have_lo && (hw_ptr || is_32);    // both halfwords used

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			insn_req <= 1'b0;
			hw_ptr   <= 1'b0;
			have_lo  <= 1'b0;
		end else begin
			if (insn_req && insn_ack) begin
				insn_req <= 1'b0;
			end else if (emit) begin
				insn_req <= 1'b1;
			end
			if (step) begin
				if (have_lo) begin
					have_lo <= 1'b0;
					hw_ptr  <= 1'b1;            // upper half came from halfword 0
				end else if (hw_ptr) begin
					hw_ptr  <= 1'b0;
					have_lo <= is_32;
				end else begin
					hw_ptr  <= !is_32;          // full word insn leaves pointer at 0
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (step && hw_ptr && !have_lo && is_32) begin
			lo_half  <= cur_hw;
			lo_addr  <= {head_addr[trig_pkg::W_ADDR-1:2], 2'b10};
			lo_brk   <= head_brk[1];            // first halfword decides the break
			lo_brk_d <= head_brk_d[1];
		end
		if (emit) begin
			if (have_lo) begin
				insn_addr         <= lo_addr;
				insn_data         <= {head_data[15:0], lo_half};
				insn_break        <= lo_brk;
				insn_break_d_mode <= lo_brk_d;
			end else begin
				insn_addr         <= {head_addr[trig_pkg::W_ADDR-1:2], hw_ptr, 1'b0};
				insn_data         <= is_32 ? head_data : {16'h0, cur_hw};
				insn_break        <= head_brk[hw_ptr];
				insn_break_d_mode <= head_brk_d[hw_ptr];
			end
		end
	end

	// fields must not move until the consumer has acked
	a_hold_fields: assert property (@(posedge clk) disable iff (!rst_n)
		insn_req && !insn_ack |=> insn_req && $stable(insn_addr) && $stable(insn_data) &&
			$stable(insn_break) && $stable(insn_break_d_mode));

endmodule

// ==== hdl/trig_top.sv ====
module trig_top (
	input  logic                        clk,
	input  logic                        rst_n,

	// config port
	input  logic                        cfg_req,
	input  logic                        cfg_write,
	input  logic [11:0]                 cfg_addr,
	input  logic [trig_pkg::W_DATA-1:0] cfg_wdata,
	output logic                        cfg_ack,
	output logic [trig_pkg::W_DATA-1:0] cfg_rdata,

	// fetch port
	input  logic                        fetch_req,
	input  logic [trig_pkg::W_ADDR-1:0] fetch_addr,     // word aligned
	input  logic [trig_pkg::W_DATA-1:0] fetch_data,
	input  logic                        fetch_m_mode,
	output logic                        fetch_ack,

	// trap events and core state
	input  logic                        event_exception,
	input  logic [3:0]                  event_trap_cause,
	input  logic                        trig_m_en,
	input  logic                        x_d_mode,
	input  logic                        x_m_mode,

	// instruction port
	output logic                        insn_req,
	input  logic                        insn_ack,
	output logic [trig_pkg::W_ADDR-1:0] insn_addr,
	output logic [31:0]                 insn_data,
	output logic                        insn_break,
	output logic                        insn_break_d_mode
);

	logic                        acc_wen;
	logic [11:0]                 acc_addr;
	logic [trig_pkg::W_DATA-1:0] acc_wdata;
	logic [trig_pkg::W_DATA-1:0] acc_rdata;

	logic [1:0] brk_any;        // lookup result for the word at fetch_addr
	logic [1:0] brk_d;

	logic                        q_full;
	logic                        q_empty;
	logic                        q_pop;
	logic [trig_pkg::W_ADDR-1:0] head_addr;
	logic [trig_pkg::W_DATA-1:0] head_data;
	logic [1:0]                  head_brk;
	logic [1:0]                  head_brk_d;

	// ------------------------------
	// fetch acceptance

	logic fetch_accept;

	// ack high means this word is already taken
	assign fetch_accept = fetch_req && !fetch_ack && !q_full;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_ack <= 1'b0;
		end else if (fetch_accept) begin
			fetch_ack <= 1'b1;
		end else if (!fetch_req) begin
			fetch_ack <= 1'b0;          // four-phase return
		end
	end

	// ------------------------------

	trig_csr_bridge u_bridge (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_req   (cfg_req),
		.cfg_write (cfg_write),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_ack   (cfg_ack),
		.cfg_rdata (cfg_rdata),
		.acc_wen   (acc_wen),
		.acc_addr  (acc_addr),
		.acc_wdata (acc_wdata),
		.acc_rdata (acc_rdata)
	);

	trig_unit u_trig (
		.clk              (clk),
		.rst_n            (rst_n),
		.cfg_addr         (acc_addr),
		.cfg_wen          (acc_wen),
		.cfg_wdata        (acc_wdata),
		.cfg_rdata        (acc_rdata),
		.trig_m_en        (trig_m_en),
		.x_d_mode         (x_d_mode),
		.x_m_mode         (x_m_mode),
		.fetch_addr       (fetch_addr),
		.fetch_m_mode     (fetch_m_mode),
		.event_exception  (event_exception),
		.event_trap_cause (event_trap_cause),
		.break_any        (brk_any),
		.break_d_mode     (brk_d)
	);

	fetch_tag_queue #(
		.DEPTH (trig_pkg::QUEUE_DEPTH_DEFAULT)
	) u_queue (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (fetch_accept),
		.push_addr  (fetch_addr),
		.push_data  (fetch_data),
		.push_brk   (brk_any),
		.push_brk_d (brk_d),
		.full       (q_full),
		.pop        (q_pop),
		.empty      (q_empty),
		.head_addr  (head_addr),
		.head_data  (head_data),
		.head_brk   (head_brk),
		.head_brk_d (head_brk_d)
	);

	insn_decode u_decode (
		.clk               (clk),
		.rst_n             (rst_n),
		.empty             (q_empty),
		.pop               (q_pop),
		.head_addr         (head_addr),
		.head_data         (head_data),
		.head_brk          (head_brk),
		.head_brk_d        (head_brk_d),
		.insn_req          (insn_req),
		.insn_ack          (insn_ack),
		.insn_addr         (insn_addr),
		.insn_data         (insn_data),
		.insn_break        (insn_break),
		.insn_break_d_mode (insn_break_d_mode)
	);

endmodule

// ==== sim/clk_gen.sv ====
module clk_gen (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;             // 40 ns period
	end

	// reset held for 8 rising edges, released off the edge
	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#2 rst_n = 1'b1;
	end

endmodule

// ==== sim/trig_tb.sv ====
module trig_tb;

	timeunit 1ns;
	timeprecision 100ps;

	logic                        clk;
	logic                        rst_n;
	logic                        cfg_req, cfg_write, cfg_ack;
	logic [11:0]                 cfg_addr;
	logic [trig_pkg::W_DATA-1:0] cfg_wdata, cfg_rdata;
	logic                        fetch_req, fetch_m_mode, fetch_ack;
	logic [trig_pkg::W_ADDR-1:0] fetch_addr;
	logic [trig_pkg::W_DATA-1:0] fetch_data;
	logic                        event_exception, trig_m_en, x_d_mode, x_m_mode;
	logic [3:0]                  event_trap_cause;
	logic                        insn_req, insn_ack, insn_break, insn_break_d_mode;
	logic [trig_pkg::W_ADDR-1:0] insn_addr;
	logic [31:0]                 insn_data;

	logic [65:0] exp_q [$];     // addr, data, break, break_d_mode
	logic        stall;         // consumer holds insn_ack low
	int          n_lines;       // stimulus length that sizes the watchdog
	int          errors, test_errs, n_tests, n_failed;
	string       cur_test;

	clk_gen u_clk (.clk(clk), .rst_n(rst_n));

	trig_top UUT (.*);

	// ------------------------------
	// helpers

	task automatic tick;
		@(posedge clk);
		#2;                                 // drive and sample off the edge
	endtask

	task automatic close_test;
		while (exp_q.size() != 0 || insn_req) tick;     // let the decoder drain
		if (cur_test != "") begin
			n_tests++;
			if (test_errs != 0) n_failed++;
			$display("test %s: %s (%0d errors)", cur_test, test_errs ? "FAILED" : "passed",
				test_errs);
		end
		test_errs = 0;
	endtask

	task automatic count_error;
		errors++;
		test_errs++;
	endtask

	// one four-phase config access with read data checked while ack is high
	task automatic cfg_access(input logic wr, input logic [11:0] addr,
		input logic [31:0] data);
		cfg_write = wr;
		cfg_addr  = addr;
		cfg_wdata = wr ? data : '0;
		cfg_req   = 1'b1;
		while (!cfg_ack) tick;
		if (!wr) begin
			assert (cfg_rdata == data) else begin
				$display("MISMATCH %0t cfg_rdata @%h expected %h got %h", $time, addr, data,
					cfg_rdata);
				count_error();
			end
		end
		cfg_req = 1'b0;
		while (cfg_ack) tick;
	endtask

	task automatic fetch_word(input logic [31:0] addr, input logic [31:0] data);
		fetch_addr = addr;
		fetch_data = data;
		fetch_req  = 1'b1;
		while (!fetch_ack) tick;
		fetch_req = 1'b0;
		while (fetch_ack) tick;
	endtask

	// queue expected full so ack must wait until the consumer runs again
	task automatic fetch_held(input logic [31:0] addr, input logic [31:0] data);
		fetch_addr = addr;
		fetch_data = data;
		fetch_req  = 1'b1;
		repeat (4) tick;
		assert (!fetch_ack) else begin
			$display("fetch_ack was granted although the prefetch queue was full");
			count_error();
		end
		stall = 1'b0;
		while (!fetch_ack) tick;
		fetch_req = 1'b0;
		while (fetch_ack) tick;
	endtask

	task automatic pulse_exception(input logic [3:0] cause);
		event_exception  = 1'b1;
		event_trap_cause = cause;
		tick;
		event_exception = 1'b0;
	endtask

	task automatic check_insn;
		logic [65:0] e;
		assert (exp_q.size() != 0) else begin
			$display("unexpected instruction at %h with nothing left in the expected list",
				insn_addr);
			count_error();
		end
		if (exp_q.size() != 0) begin
			e = exp_q.pop_front();
			assert (insn_addr == e[65:34]) else begin
				$display("MISMATCH %0t insn_addr expected %h got %h", $time, e[65:34],
					insn_addr);
				count_error();
			end
			assert (insn_data == e[33:2]) else begin
				$display("MISMATCH %0t insn_data expected %h got %h", $time, e[33:2],
					insn_data);
				count_error();
			end
			assert (insn_break == e[1]) else begin
				$display("MISMATCH %0t insn_break expected %b got %b", $time, e[1],
					insn_break);
				count_error();
			end
			assert (insn_break_d_mode == e[0]) else begin
				$display("MISMATCH %0t insn_break_d_mode expected %b got %b", $time, e[0],
					insn_break_d_mode);
				count_error();
			end
		end
	endtask

	// ------------------------------
	// instruction consumer with random ack delay

	initial begin
		int delay;
		forever begin
			tick;
			if (insn_req && !insn_ack && !stall) begin
				delay = $urandom_range(5, 0);
				repeat (delay) tick;
				check_insn();
				insn_ack = 1'b1;
				while (insn_req) tick;
				insn_ack = 1'b0;
			end
		end
	end

	// watchdog allows 40 cycles for every stimulus line
	initial begin
		wait (n_lines > 0);
		#(n_lines * 40 * 40);
		$display("watchdog expired before the stimulus finished");
		$display("Something failed");
		$finish;
	end

	// ------------------------------
	// stimulus reader

	initial begin
		int          fd;
		int          cnt;
		string       line, cmd, name;
		logic [31:0] f0, f1, f2, f3;
		cfg_req          = 1'b0;
		cfg_write        = 1'b0;
		cfg_addr         = '0;
		cfg_wdata        = '0;
		fetch_req        = 1'b0;
		fetch_addr       = '0;
		fetch_data       = '0;
		fetch_m_mode     = 1'b1;
		event_exception  = 1'b0;
		event_trap_cause = '0;
		trig_m_en        = 1'b1;
		x_d_mode         = 1'b0;
		x_m_mode         = 1'b1;
		insn_ack         = 1'b0;
		stall            = 1'b0;
		n_lines          = 0;
		cnt              = 0;
		errors           = 0;
		test_errs        = 0;
		n_tests          = 0;
		n_failed         = 0;
		cur_test         = "";
		void'($urandom(71678));
		fd = $fopen("sim/trig_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file sim/trig_stim.txt");
			$display("Something failed");
			$finish;
		end else begin
			while ($fgets(line, fd) != 0) cnt++;
			$fclose(fd);
			n_lines = cnt;
			fd = $fopen("sim/trig_stim.txt", "r");
			wait (rst_n);
			tick;
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line.getc(0) == "#") continue;   // comment or blank
				f0 = '0;
				f1 = '0;
				f2 = '0;
				f3 = '0;
				void'($sscanf(line, "%s %h %h %h %h", cmd, f0, f1, f2, f3));
				case (cmd)
					"T": begin
						close_test();
						void'($sscanf(line, "%s %s", cmd, name));
						cur_test = name;
					end
					"W": cfg_access(1'b1, f0[11:0], f1);
					"R": cfg_access(1'b0, f0[11:0], f1);
					"D": begin
						x_d_mode = f0[0];
						tick;
					end
					"M": begin
						x_m_mode     = f0[0];
						fetch_m_mode = f0[0];
					end
					"E": pulse_exception(f0[3:0]);
					"F": fetch_word(f0, f1);
					"P": fetch_held(f0, f1);
					"B": stall = f0[0];
					"I": exp_q.push_back({f0, f1, f2[0], f3[0]});
					default: begin
						$display("unknown stimulus command: %s", line);
						count_error();
					end
				endcase
			end
			$fclose(fd);
			close_test();
			$display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
			if (errors == 0) begin
				$display("Everything OK");
			end else begin
				$display("Something failed");
			end
			$finish;
		end
	end

endmodule

// ==== sim/trig_stim.txt ====
# W addr data | R addr expected | D x_d_mode | M m_mode | E cause | B stall
# F addr data | P addr data (held back) | I addr data brk brk_d | T name
T config_readback
W 7a0 0
R 7a0 0
W 7a1 44
R 7a1 20000044
W 7a2 1003
R 7a2 1002
R 7a4 4
W 7a0 2
R 7a0 2
R 7a4 20
W 7a2 ffff
R 7a2 9f6
T dmode_protect
W 7a1 08000240
R 7a1 58000241
W 7a2 2
R 7a2 9f6
W 7a1 0
R 7a1 58000241
D 1
W 7a2 4
R 7a2 4
W 7a0 1
W 7a1 08001044
R 7a1 28001044
W 7a2 1008
R 7a2 1008
D 0
W 7a2 2000
R 7a2 1008
T break_tag_assembly
I 1000 4501 0 0
I 1002 00100793 1 0
I 1006 8082 0 0
I 1008 00a00513 1 1
I 100c 4505 0 0
I 100e 4601 0 0
F 1000 07934501
F 1004 80820010
F 1008 00a00513
F 100c 46014505
M 0
I 1008 00a00513 0 0
I 100c 4505 0 0
I 100e 4601 0 0
F 1008 00a00513
F 100c 46014505
M 1
T exception_trigger
I 100c 4505 0 0
I 100e 4601 0 0
E 5
E 3
F 100c 46014505
I 100c 4505 1 1
I 100e 4601 1 1
E 2
F 100c 46014505
I 100c 4505 0 0
I 100e 4601 0 0
D 1
D 0
F 100c 46014505
T back_pressure
B 1
I 2000 4111 0 0
I 2002 2111 0 0
I 2004 4221 0 0
I 2006 2221 0 0
I 2008 4331 0 0
I 200a 2331 0 0
I 200c 4441 0 0
I 200e 2441 0 0
I 2010 4551 0 0
I 2012 2551 0 0
F 2000 21114111
F 2004 22214221
F 2008 23314331
F 200c 24414441
P 2010 25514551

// ==== sources.f ====
hdl/trig_pkg.sv
hdl/trig_csr_bridge.sv
hdl/trig_unit.sv
hdl/fetch_tag_queue.sv
hdl/insn_decode.sv
hdl/trig_top.sv
sim/clk_gen.sv
sim/trig_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the trigger testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module trig_tb -o trig_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/trig_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
